// ==== source/mge_pkg.sv ====
// Multi-rate Ethernet control package with constants, CSR map and shared types
package mge_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int NUM_CHANNELS = 4;
    localparam int MODE_W       = 2;
    localparam int CSR_ADDR_W   = 2;
    localparam int CSR_DATA_W   = 32;

    // Speed mode that runs from the 1G PLL
    localparam logic [MODE_W-1:0] MODE_1G = 2'd0;

    // ----------------------------------------
    // CSR map
    // ----------------------------------------
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MODE    = 2'd0;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_START   = 2'd1;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_BUSY    = 2'd2;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_VERSION = 2'd3;

    localparam logic [CSR_DATA_W-1:0] RCFG_VERSION = 32'h0001_0300;

    // ----------------------------------------
    // Timing, in csr_clk cycles
    // ----------------------------------------
    localparam int RCFG_BUSY_CYCLES     = 16;
    localparam int ANALOG_RESET_CYCLES  = 8;
    localparam int DIGITAL_DELAY_CYCLES = 8;
    localparam int LINK_STABLE_CYCLES   = 12;

    // Counter widths derived from the timing above
    localparam int BUSY_CNT_W   = $clog2(RCFG_BUSY_CYCLES + 1);
    localparam int ANALOG_CNT_W = $clog2(ANALOG_RESET_CYCLES);
    localparam int DIG_CNT_W    = $clog2(DIGITAL_DELAY_CYCLES);
    localparam int LINK_CNT_W   = $clog2(LINK_STABLE_CYCLES);

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [MODE_W-1:0] mode_t;

    typedef struct packed {
        logic [CSR_ADDR_W-1:0] address;
        logic                  read;
        logic                  write;
        logic [CSR_DATA_W-1:0] writedata;
    } csr_req_t;

    // Bit 1 is the 1G PLL, bit 0 the 2.5G PLL
    typedef struct packed {
        logic [1:0] locked;
        logic [1:0] cal_busy;
    } pll_status_t;

    typedef struct packed {
        logic rx_is_lockedtodata;
        logic tx_cal_busy;
        logic rx_cal_busy;
    } xcvr_status_t;

    typedef struct packed {
        logic tx_analog;
        logic rx_analog;
        logic tx_digital;
        logic rx_digital;
    } xcvr_resets_t;

endpackage

// ==== source/mge_rcfg_ctrl.sv ====
// Reconfiguration CSR holding requested and active speed modes and busy timers
`timescale 1ns/1ps

module mge_rcfg_ctrl (
    input  logic                                               csr_clk,
    input  logic                                               rst_n,

    // CSR
    input  mge_pkg::csr_req_t                                  csr,
    output logic [mge_pkg::CSR_DATA_W-1:0]                     csr_readdata,

    // Per-channel reconfiguration outputs
    output mge_pkg::mode_t [mge_pkg::NUM_CHANNELS-1:0]         xcvr_mode,
    output logic [mge_pkg::NUM_CHANNELS-1:0]                   reconfig_busy
);

    // Requested modes, written through the MODE address
    mge_pkg::mode_t [mge_pkg::NUM_CHANNELS-1:0] mode_req;

    // Remaining busy cycles per channel
    logic [mge_pkg::NUM_CHANNELS-1:0][mge_pkg::BUSY_CNT_W-1:0] busy_cnt;

    logic mode_wr;
    logic start_wr;

    // ----------------------------------------
    // CSR decode
    // ----------------------------------------
    assign mode_wr  = csr.write && (csr.address == mge_pkg::CSR_ADDR_MODE);
    assign start_wr = csr.write && (csr.address == mge_pkg::CSR_ADDR_START);

    always_ff @(posedge csr_clk) begin
        if (!rst_n) begin
            mode_req <= '0;
        end else if (mode_wr) begin
            for (int i = 0; i < mge_pkg::NUM_CHANNELS; i++) begin
                mode_req[i] <= csr.writedata[mge_pkg::MODE_W*i +: mge_pkg::MODE_W];
            end
        end
    end

    // ----------------------------------------
    // Start and busy timing per channel
    // ----------------------------------------
    always_ff @(posedge csr_clk) begin
        if (!rst_n) begin
            xcvr_mode <= '0;
            busy_cnt  <= '0;
        end else begin
            for (int i = 0; i < mge_pkg::NUM_CHANNELS; i++) begin
                if (start_wr && csr.writedata[i] && !reconfig_busy[i]) begin
                    // Apply the requested mode and open the busy window
                    xcvr_mode[i] <= mode_req[i];
                    busy_cnt[i]  <= mge_pkg::BUSY_CNT_W'(mge_pkg::RCFG_BUSY_CYCLES);
                end else if (reconfig_busy[i]) begin
                    busy_cnt[i] <= busy_cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < mge_pkg::NUM_CHANNELS; i++) begin
            reconfig_busy[i] = (busy_cnt[i] != '0);
        end
    end

    // ----------------------------------------
    // Read data, one cycle after the strobe
    // ----------------------------------------
    always_ff @(posedge csr_clk) begin
        if (csr.read) begin
            case (csr.address)
                mge_pkg::CSR_ADDR_MODE: begin
                    csr_readdata <= mge_pkg::CSR_DATA_W'(mode_req);
                end
                mge_pkg::CSR_ADDR_START: begin
                    // Start address reads back the modes in use
                    csr_readdata <= mge_pkg::CSR_DATA_W'(xcvr_mode);
                end
                mge_pkg::CSR_ADDR_BUSY: begin
                    csr_readdata <= mge_pkg::CSR_DATA_W'(reconfig_busy);
                end
                default: begin
                    csr_readdata <= mge_pkg::RCFG_VERSION;
                end
            endcase
        end
    end

endmodule

// ==== source/mge_xcvr_reset_seq.sv ====
// Transceiver reset sequencer for one channel with TX PLL selection by speed mode
`timescale 1ns/1ps

module mge_xcvr_reset_seq (
    input  logic                  csr_clk,
    input  logic                  rst_n,

    // Reconfiguration state of this channel
    input  mge_pkg::mode_t        mode,
    input  logic                  reconfig_busy,

    // Transceiver and PLL status
    input  mge_pkg::pll_status_t  pll_status,
    input  mge_pkg::xcvr_status_t xcvr_status,

    // Reset outputs and readiness
    output mge_pkg::xcvr_resets_t resets,
    output logic                  tx_ready,
    output logic                  rx_ready
);

    // Sides of the digital sequencing, index 1 is TX and 0 is RX
    localparam int SIDES = 2;

    logic                         restart;
    logic                         pll_sel;
    logic                         analog_rst;
    logic [mge_pkg::ANALOG_CNT_W-1:0] analog_cnt;

    logic [SIDES-1:0]             side_cond;
    logic [SIDES-1:0]             digital_rst;
    logic [SIDES-1:0]             side_ready;
    logic [SIDES-1:0][mge_pkg::DIG_CNT_W-1:0] dig_cnt;

    // ----------------------------------------
    // PLL selection
    // ----------------------------------------
    // 1G runs on PLL 1, 2.5G and the reserved modes on PLL 0
    assign pll_sel = (mode == mge_pkg::MODE_1G);

    assign side_cond[1] = pll_status.locked[pll_sel] &&
                          !pll_status.cal_busy[pll_sel] &&
                          !xcvr_status.tx_cal_busy;

    assign side_cond[0] = xcvr_status.rx_is_lockedtodata && !xcvr_status.rx_cal_busy;

    // A reconfiguration restarts the whole sequence
    assign restart = !rst_n || reconfig_busy;

    // ----------------------------------------
    // Analog reset hold
    // ----------------------------------------
    always_ff @(posedge csr_clk) begin
        if (restart) begin
            analog_rst <= 1'b1;
            analog_cnt <= '0;
        end else if (analog_rst) begin
            if (analog_cnt == mge_pkg::ANALOG_CNT_W'(mge_pkg::ANALOG_RESET_CYCLES - 1)) begin
                analog_rst <= 1'b0;
            end else begin
                analog_cnt <= analog_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Digital release, TX and RX independent
    // ----------------------------------------
    always_ff @(posedge csr_clk) begin
        for (int s = 0; s < SIDES; s++) begin
            if (restart || analog_rst || !side_cond[s]) begin
                // Held in reset until the condition has been stable long enough
                digital_rst[s] <= 1'b1;
                side_ready[s]  <= 1'b0;
                dig_cnt[s]     <= '0;
            end else if (digital_rst[s]) begin
                if (dig_cnt[s] == mge_pkg::DIG_CNT_W'(mge_pkg::DIGITAL_DELAY_CYCLES - 1)) begin
                    digital_rst[s] <= 1'b0;
                    side_ready[s]  <= 1'b1;
                end else begin
                    dig_cnt[s] <= dig_cnt[s] + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    always_comb begin
        resets.tx_analog  = analog_rst;
        resets.rx_analog  = analog_rst;
        resets.tx_digital = digital_rst[1];
        resets.rx_digital = digital_rst[0];
    end

    assign tx_ready = side_ready[1];
    assign rx_ready = side_ready[0];

endmodule

// ==== source/mge_channel_status.sv ====
// Channel readiness from reset sequencer state and a debounced link indication
`timescale 1ns/1ps

module mge_channel_status (
    input  logic csr_clk,
    input  logic rst_n,

    // From the reset sequencer
    input  logic tx_ready,
    input  logic rx_ready,

    // Link indication from the PHY
    input  logic link,

    // Data path readiness
    output logic channel_tx_ready,
    output logic channel_rx_ready
);

    logic                           link_ok;
    logic [mge_pkg::LINK_CNT_W-1:0] link_cnt;

    assign link_ok = rx_ready && link;

    // TX side only needs the sequencer
    always_ff @(posedge csr_clk) begin
        if (!rst_n) begin
            channel_tx_ready <= 1'b0;
        end else begin
            channel_tx_ready <= tx_ready;
        end
    end

    // ----------------------------------------
    // RX side waits for a stable link
    // ----------------------------------------
    always_ff @(posedge csr_clk) begin
        if (!rst_n || !link_ok) begin
            channel_rx_ready <= 1'b0;
            link_cnt         <= '0;
        end else if (!channel_rx_ready) begin
            if (link_cnt == mge_pkg::LINK_CNT_W'(mge_pkg::LINK_STABLE_CYCLES - 1)) begin
                channel_rx_ready <= 1'b1;
            end else begin
                link_cnt <= link_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/mge_rd_top.sv ====
// Control top level with reconfiguration CSR, reset sequencers and channel status
`timescale 1ns/1ps

module mge_rd_top (
    input  logic                                               csr_clk,
    input  logic                                               rst_n,

    // Reconfiguration CSR
    input  mge_pkg::csr_req_t                                  csr,
    output logic [mge_pkg::CSR_DATA_W-1:0]                     csr_readdata,

    // Transceiver and PLL status
    input  mge_pkg::pll_status_t                               pll_status,
    input  mge_pkg::xcvr_status_t [mge_pkg::NUM_CHANNELS-1:0]  xcvr_status,
    input  logic [mge_pkg::NUM_CHANNELS-1:0]                   link,

    // Transceiver control
    output mge_pkg::mode_t [mge_pkg::NUM_CHANNELS-1:0]         xcvr_mode,
    output mge_pkg::xcvr_resets_t [mge_pkg::NUM_CHANNELS-1:0]  xcvr_resets,

    // Data path readiness
    output logic [mge_pkg::NUM_CHANNELS-1:0]                   channel_tx_ready,
    output logic [mge_pkg::NUM_CHANNELS-1:0]                   channel_rx_ready
);

    logic [mge_pkg::NUM_CHANNELS-1:0] reconfig_busy;
    logic [mge_pkg::NUM_CHANNELS-1:0] reset_tx_ready;
    logic [mge_pkg::NUM_CHANNELS-1:0] reset_rx_ready;

    // Shared reconfiguration block
    mge_rcfg_ctrl u_rcfg_ctrl (
        .csr_clk       (csr_clk),
        .rst_n         (rst_n),
        .csr           (csr),
        .csr_readdata  (csr_readdata),
        .xcvr_mode     (xcvr_mode),
        .reconfig_busy (reconfig_busy)
    );

    // ----------------------------------------
    // Per-channel control
    // ----------------------------------------
    for (genvar i = 0; i < mge_pkg::NUM_CHANNELS; i++) begin : g_channel

        mge_xcvr_reset_seq u_reset_seq (
            .csr_clk       (csr_clk),
            .rst_n         (rst_n),
            .mode          (xcvr_mode[i]),
            .reconfig_busy (reconfig_busy[i]),
            .pll_status    (pll_status),
            .xcvr_status   (xcvr_status[i]),
            .resets        (xcvr_resets[i]),
            .tx_ready      (reset_tx_ready[i]),
            .rx_ready      (reset_rx_ready[i])
        );

        mge_channel_status u_channel_status (
            .csr_clk          (csr_clk),
            .rst_n            (rst_n),
            .tx_ready         (reset_tx_ready[i]),
            .rx_ready         (reset_rx_ready[i]),
            .link             (link[i]),
            .channel_tx_ready (channel_tx_ready[i]),
            .channel_rx_ready (channel_rx_ready[i])
        );

    end

endmodule

// ==== tb/mge_rd_checker.sv ====
// Bound assertions on the transceiver reset sequencer outputs
`timescale 1ns/1ps

module mge_rd_checker (
    input logic                  csr_clk,
    input logic                  rst_n,
    input logic                  reconfig_busy,
    input mge_pkg::xcvr_resets_t resets,
    input logic                  tx_ready,
    input logic                  rx_ready
);

    // Digital release only after the analog release
    tx_reset_order: assert property (@(posedge csr_clk) disable iff (!rst_n)
        resets.tx_analog |-> resets.tx_digital)
        else $error("tx_digital released while tx_analog is held");

    rx_reset_order: assert property (@(posedge csr_clk) disable iff (!rst_n)
        resets.rx_analog |-> resets.rx_digital)
        else $error("rx_digital released while rx_analog is held");

    // ----------------------------------------
    // Readiness against the digital resets
    // ----------------------------------------
    tx_ready_release: assert property (@(posedge csr_clk) disable iff (!rst_n)
        tx_ready |-> !resets.tx_digital)
        else $error("tx_ready high while tx_digital is held");

    rx_ready_release: assert property (@(posedge csr_clk) disable iff (!rst_n)
        rx_ready |-> !resets.rx_digital)
        else $error("rx_ready high while rx_digital is held");

    // Busy is registered into the restart one edge later
    busy_holds_resets: assert property (@(posedge csr_clk) disable iff (!rst_n)
        reconfig_busy |=> (resets.tx_analog && resets.rx_analog &&
                           resets.tx_digital && resets.rx_digital))
        else $error("Reset released during a reconfiguration");

endmodule

bind mge_xcvr_reset_seq mge_rd_checker u_rd_checker (
    .csr_clk       (csr_clk),
    .rst_n         (rst_n),
    .reconfig_busy (reconfig_busy),
    .resets        (resets),
    .tx_ready      (tx_ready),
    .rx_ready      (rx_ready)
);

// ==== tb/mge_rd_top_tb.sv ====
// Testbench for the multi-rate Ethernet control top level
`timescale 1ns/1ps

module mge_rd_top_tb;

    logic                                              csr_clk;
    logic                                              rst_n;
    mge_pkg::csr_req_t                                 csr;
    logic [mge_pkg::CSR_DATA_W-1:0]                    csr_readdata;
    mge_pkg::pll_status_t                              pll_status;
    mge_pkg::xcvr_status_t [mge_pkg::NUM_CHANNELS-1:0] xcvr_status;
    logic [mge_pkg::NUM_CHANNELS-1:0]                  link;
    mge_pkg::mode_t [mge_pkg::NUM_CHANNELS-1:0]        xcvr_mode;
    mge_pkg::xcvr_resets_t [mge_pkg::NUM_CHANNELS-1:0] xcvr_resets;
    logic [mge_pkg::NUM_CHANNELS-1:0]                  channel_tx_ready;
    logic [mge_pkg::NUM_CHANNELS-1:0]                  channel_rx_ready;

    // Configuration as the testbench has set it
    mge_pkg::mode_t [mge_pkg::NUM_CHANNELS-1:0]        req_modes;
    mge_pkg::mode_t [mge_pkg::NUM_CHANNELS-1:0]        active_modes;
    logic [2*mge_pkg::NUM_CHANNELS-1:0]                cmp_expected;
    logic [31:0]                                       rdata;
    integer                                            seed;
    event                                              compare_now;

    mge_rd_top mge_rd_top_i (.*);

    initial begin
        csr_clk = 1'b0;
        forever #5 csr_clk = ~csr_clk;
    end

    // Final readiness per channel, rx in the upper half and tx in the lower half
    function automatic logic [2*mge_pkg::NUM_CHANNELS-1:0] expected_ready(
        input mge_pkg::mode_t [mge_pkg::NUM_CHANNELS-1:0]        modes,
        input mge_pkg::pll_status_t                              pll,
        input mge_pkg::xcvr_status_t [mge_pkg::NUM_CHANNELS-1:0] xs,
        input logic [mge_pkg::NUM_CHANNELS-1:0]                  lk
    );
        logic [2*mge_pkg::NUM_CHANNELS-1:0] res;
        int p;
        res = '0;
        for (int i = 0; i < mge_pkg::NUM_CHANNELS; i++) begin
            // Mode 0 is 1G on PLL 1, the rest run on PLL 0
            p = (modes[i] == 2'd0) ? 1 : 0;
            res[i] = pll.locked[p] && !pll.cal_busy[p] && !xs[i].tx_cal_busy;
            res[mge_pkg::NUM_CHANNELS+i] = xs[i].rx_is_lockedtodata &&
                                           !xs[i].rx_cal_busy && lk[i];
        end
        return res;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Comparing process, woken after each settle wait
    always @(compare_now) begin
        cmp_expected = expected_ready(active_modes, pll_status, xcvr_status, link);
        check_value("channel_tx_ready", 32'(channel_tx_ready),
                    32'(cmp_expected[mge_pkg::NUM_CHANNELS-1:0]));
        check_value("channel_rx_ready", 32'(channel_rx_ready),
                    32'(cmp_expected[2*mge_pkg::NUM_CHANNELS-1:mge_pkg::NUM_CHANNELS]));
        check_value("xcvr_mode", 32'(xcvr_mode), 32'(active_modes));
    end

    // ----------------------------------------
    // CSR access, called on a falling edge
    // ----------------------------------------
    task automatic csr_write(input logic [1:0] addr, input logic [31:0] data);
        csr.address   = addr;
        csr.writedata = data;
        csr.write     = 1'b1;
        @(negedge csr_clk);
        csr.write = 1'b0;
    endtask

    task automatic csr_read(input logic [1:0] addr, output logic [31:0] data);
        csr.address = addr;
        csr.read    = 1'b1;
        @(negedge csr_clk);
        csr.read = 1'b0;
        data     = csr_readdata;
    endtask

    // Wait until readiness holds for longer than a full re-sequence
    task automatic settle_and_compare();
        logic [2*mge_pkg::NUM_CHANNELS-1:0] last;
        int window;
        int stable;
        window = mge_pkg::ANALOG_RESET_CYCLES + mge_pkg::DIGITAL_DELAY_CYCLES +
                 mge_pkg::LINK_STABLE_CYCLES + 4;
        last   = {channel_rx_ready, channel_tx_ready};
        stable = 0;
        for (int n = 0; n < 400 && stable < window; n++) begin
            @(negedge csr_clk);
            if ({channel_rx_ready, channel_tx_ready} == last) begin
                stable++;
            end else begin
                stable = 0;
            end
            last = {channel_rx_ready, channel_tx_ready};
        end
        if (stable < window) begin
            abort_run("Channel readiness did not settle before the timeout");
        end
        -> compare_now;
        @(negedge csr_clk);
    endtask

    // Start channels and poll BUSY; the other channels must keep their readiness
    task automatic start_channels(input logic [mge_pkg::NUM_CHANNELS-1:0] started);
        logic [2*mge_pkg::NUM_CHANNELS-1:0] exp;
        logic [31:0] busy;
        exp  = expected_ready(active_modes, pll_status, xcvr_status, link);
        busy = '1;
        for (int i = 0; i < mge_pkg::NUM_CHANNELS; i++) begin
            if (started[i]) begin
                active_modes[i] = req_modes[i];
            end
        end
        csr_write(mge_pkg::CSR_ADDR_START, 32'(started));
        for (int n = 0; n < 4 * mge_pkg::RCFG_BUSY_CYCLES && busy != 0; n++) begin
            csr_read(mge_pkg::CSR_ADDR_BUSY, busy);
            if (n == 0) begin
                check_value("busy", busy, 32'(started));
                for (int i = 0; i < mge_pkg::NUM_CHANNELS; i++) begin
                    if (started[i]) begin
                        check_value("xcvr_resets", 32'(xcvr_resets[i]), 32'hf);
                    end
                end
            end
            check_value("channel ready",
                        32'({channel_rx_ready, channel_tx_ready} & ~{started, started}),
                        32'(exp & ~{started, started}));
        end
        if (busy != 0) begin
            abort_run("BUSY did not clear before the timeout");
        end
        check_value("started readiness", 32'({channel_rx_ready, channel_tx_ready} &
                                               {started, started}), 32'h0);
    endtask

    initial begin
        seed         = 32'h566ca2fc;
        rst_n        = 1'b0;
        csr          = '0;
        pll_status   = 4'b11_00;
        // CDR locked, no calibration running
        xcvr_status  = {mge_pkg::NUM_CHANNELS{3'b100}};
        link         = '1;
        req_modes    = '0;
        active_modes = '0;

        // Reset state and version
        repeat (16) @(negedge csr_clk);
        check_value("xcvr_resets", 32'(xcvr_resets), 32'h0000_ffff);
        check_value("channel ready", 32'({channel_rx_ready, channel_tx_ready}), 32'h0);
        rst_n = 1'b1;
        @(negedge csr_clk);
        check_value("xcvr_resets", 32'(xcvr_resets), 32'h0000_ffff);
        check_value("channel ready", 32'({channel_rx_ready, channel_tx_ready}), 32'h0);
        csr_read(mge_pkg::CSR_ADDR_VERSION, rdata);
        check_value("version", rdata, mge_pkg::RCFG_VERSION);
        settle_and_compare();

        // Random modes, readback and start on all channels
        rdata     = $random(seed);
        req_modes = rdata[2*mge_pkg::NUM_CHANNELS-1:0];
        // Keep at least one channel on each PLL
        req_modes[0]    = 2'd0;
        req_modes[1][0] = 1'b1;
        csr_write(mge_pkg::CSR_ADDR_MODE, 32'(req_modes));
        csr_read(mge_pkg::CSR_ADDR_MODE, rdata);
        check_value("requested modes", rdata, 32'(req_modes));
        start_channels('1);
        csr_read(mge_pkg::CSR_ADDR_START, rdata);
        check_value("active modes", rdata, 32'(active_modes));
        settle_and_compare();

        // PLL selection, one PLL locked at a time
        pll_status.locked = 2'b10;
        settle_and_compare();
        pll_status.locked = 2'b01;
        settle_and_compare();
        pll_status.locked = 2'b11;
        settle_and_compare();

        // RX readiness against calibration, CDR lock and link
        xcvr_status[1].rx_cal_busy        = 1'b1;
        xcvr_status[2].rx_is_lockedtodata = 1'b0;
        link[0]                           = 1'b0;
        settle_and_compare();
        xcvr_status = {mge_pkg::NUM_CHANNELS{3'b100}};
        link        = '1;
        settle_and_compare();

        // Reconfigure channel 2 only, into another mode
        req_modes[2] = active_modes[2] ^ 2'd1;
        csr_write(mge_pkg::CSR_ADDR_MODE, 32'(req_modes));
        start_channels(4'b0100);
        settle_and_compare();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== mge_rd_top.f ====
source/mge_pkg.sv
source/mge_rcfg_ctrl.sv
source/mge_xcvr_reset_seq.sv
source/mge_channel_status.sv
source/mge_rd_top.sv
tb/mge_rd_checker.sv
tb/mge_rd_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the control top level and its testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mge_rd_top_tb -f mge_rd_top.f

output=$(./obj_dir/Vmge_rd_top_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
